// ==== verilog.f ====
+incdir+hw
hw/fb_pkg.sv
hw/pixel_fifo.sv
hw/vga_timing.sv
hw/fb_writer.sv
hw/fb_reader.sv
hw/fb_ctrl_regs.sv
hw/frame_buffer_top.sv
dv/sram_model.sv
dv/tb_frame_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the frame buffer testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_frame_buffer -f verilog.f -o sim_frame_buffer &&
./obj_dir/sim_frame_buffer 2>&1 | tee sim.log ||
{ echo "simulation build or run failed"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "result: failed"; exit 1; } ||
{ grep -q "=== PASS ===" sim.log && echo "result: passed" || { echo "result: no verdict"; exit 1; }; }

// ==== dv/tb_frame_buffer.sv ====
`include "fb_defs.svh"

module tb_frame_buffer;

    timeunit 1ns;
    timeprecision 1ps;

    import fb_pkg::*;

    localparam int NUM_PIX  = `FB_H_VISIBLE * `FB_V_VISIBLE;
    localparam int FRAME_CK = `FB_H_TOTAL * `FB_V_TOTAL * 2;
    localparam int TIMEOUT  = FRAME_CK * 3 * 11 / 10;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  pix_push;
    pixel_entry_t          pix_entry;
    logic                  pix_full;
    logic                  cfg_we;
    logic [1:0]            cfg_addr;
    logic [31:0]           cfg_wdata;
    logic [31:0]           cfg_rdata;
    logic [`FB_ADDR_W-1:0] sram_addr;
    wire  [`FB_DATA_W-1:0] sram_io;
    logic                  sram_we_b, sram_oe_b, sram_ce_b, sram_ub_b, sram_lb_b;
    logic                  hs, vs, vga_clk, vga_blank;
    color_t                vga_rgb;

    color_t shadow [NUM_PIX];
    color_t expected_rgb;
    int     seed = 32'hffe0d48b;
    int     errors = 0;
    int     sync_errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     cycles = 0;
    int     accepted_count = 0;
    int     pix_checked = 0;
    int     hs_periods = 0;
    int     check_mode = 0;
    logic   chk_reset = 1'b0;
    logic   hs_q, hs_armed, blank_q, next_row0;
    int     hs_low, hs_per, vs_low, row_cnt, col_cnt;

    frame_buffer_top frame_buffer_top_inst (.*);

    sram_model u_sram (
        .addr(sram_addr), .io(sram_io), .we_b(sram_we_b), .oe_b(sram_oe_b),
        .ce_b(sram_ce_b), .ub_b(sram_ub_b), .lb_b(sram_lb_b)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, frames did not complete", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error: %s at %0t", what, $time);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    // stripe rule: column bits 8..6 on the msb of each colour
    function automatic color_t stripe_color(input int col);
        color_t c;
        c = '0;
        c.red[7]   = col[8];
        c.green[7] = col[7];
        c.blue[7]  = col[6];
        return c;
    endfunction

    always_comb begin
        if (check_mode == 2) begin
            expected_rgb = stripe_color(col_cnt);
        end else if (row_cnt * `FB_H_VISIBLE + col_cnt < NUM_PIX) begin
            expected_rgb = shadow[row_cnt * `FB_H_VISIBLE + col_cnt];
        end else begin
            expected_rgb = '0;
        end
    end

    // sync pulse and raster position trackers
    always @(posedge clk) begin
        if (rst) begin
            hs_q      <= 1'b1;
            hs_armed  <= 1'b0;
            blank_q   <= 1'b1;
            next_row0 <= 1'b0;
            hs_low    <= 0;
            hs_per    <= 0;
            vs_low    <= 0;
            row_cnt   <= 0;
            col_cnt   <= 0;
        end else begin
            hs_q    <= hs;
            blank_q <= vga_blank;
            hs_low  <= hs ? 0 : hs_low + 1;
            vs_low  <= vs ? 0 : vs_low + 1;
            if (hs_q && !hs) begin
                hs_per   <= 1;
                hs_armed <= 1'b1;
                hs_periods++;
            end else begin
                hs_per <= hs_per + 1;
            end
            if (blank_q && !vga_blank) begin
                col_cnt   <= 0;
                row_cnt   <= next_row0 ? 0 : row_cnt + 1;
                next_row0 <= 1'b0;
            end else if (vga_clk && !vga_blank) begin
                col_cnt <= col_cnt + 1;
                if (check_mode != 0) begin
                    pix_checked++;
                end
            end
            if (!vs) begin
                next_row0 <= 1'b1;
            end
        end
    end

    a_reset_state : assert property (@(posedge clk) chk_reset |->
        ({hs, vs, vga_blank, sram_we_b, sram_oe_b, pix_full} == 6'b111110))
        else report_mismatch("hs,vs,vga_blank,sram_we_b,sram_oe_b,pix_full",
            $sampled({hs, vs, vga_blank, sram_we_b, sram_oe_b, pix_full}), 32'h3e);

    a_hs_period : assert property (@(posedge clk) disable iff (rst)
        ($fell(hs) && hs_armed) |-> (hs_per == `FB_H_TOTAL * 2))
        else begin
            sync_errors++;
            report_mismatch("hs_period", $sampled(hs_per), `FB_H_TOTAL * 2);
        end

    a_hs_low : assert property (@(posedge clk) disable iff (rst)
        $rose(hs) |-> (hs_low == (`FB_H_SYNC - `FB_H_FRONT) * 2))
        else begin
            sync_errors++;
            report_mismatch("hs_low", $sampled(hs_low), (`FB_H_SYNC - `FB_H_FRONT) * 2);
        end

    a_vs_low : assert property (@(posedge clk) disable iff (rst)
        $rose(vs) |-> (vs_low == (`FB_V_SYNC - `FB_V_FRONT) * `FB_H_TOTAL * 2))
        else begin
            sync_errors++;
            report_mismatch("vs_low", $sampled(vs_low),
                (`FB_V_SYNC - `FB_V_FRONT) * `FB_H_TOTAL * 2);
        end

    a_pixel : assert property (@(posedge clk) disable iff (rst)
        ((check_mode != 0) && vga_clk && !vga_blank) |-> (vga_rgb == expected_rgb))
        else report_mismatch("vga_rgb", $sampled(vga_rgb), $sampled(expected_rgb));

    task automatic push_pixel(input logic [18:0] id, input color_t c, input logic wait_ready,
                              output logic accepted);
        @(negedge clk);
        while (wait_ready && pix_full) begin
            pix_push = 1'b0;
            @(negedge clk);
        end
        accepted = !pix_full;
        pix_push = 1'b1;
        pix_entry.pixel_id = id;
        pix_entry.color = c;
        if (accepted) begin
            shadow[id] = c;
            accepted_count++;
        end
    endtask

    // neighbouring ids share a word, so write them in pairs
    task automatic push_random_pairs(input int count);
        logic [18:0] base;
        logic        ok;
        for (int i = 0; i < count; i++) begin
            if (i % 2 == 0) begin
                base = 19'({$random(seed)} % (NUM_PIX - 1));
            end else begin
                base = base + 19'd1;
            end
            push_pixel(base, color_t'($random(seed)), 1'b1, ok);
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        pix_push  = 1'b0;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
        @(negedge clk);
        pix_push = 1'b0;
        cfg_we   = 1'b0;
        cfg_addr = addr;
        @(posedge clk);
        data = cfg_rdata;
    endtask

    task automatic wait_frame_start();
        logic prev;
        do begin
            prev = vs;
            @(negedge clk);
        end while (!(prev && !vs));
    endtask

    // checks one whole frame, from one vsync to the next
    task automatic run_frame(input int mode);
        check_mode  = mode;
        pix_checked = 0;
        wait_frame_start();
        check_mode = 0;
        assert (pix_checked == NUM_PIX)
            else report_failure("frame did not present every visible pixel");
    endtask

    initial begin
        logic        ok;
        logic [31:0] rd;
        int          err0;
        int          dropped;
        int          polls;

        for (int i = 0; i < NUM_PIX; i++) begin
            shadow[i] = '0;
        end
        rst = 1'b1;
        pix_push = 1'b0;
        pix_entry = '0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        chk_reset = 1'b1;
        @(negedge clk);
        chk_reset = 1'b0;
        finish_test("reset_state", 0);

        push_random_pairs(256);

        err0 = errors;
        dropped = 0;
        for (int i = 0; i < 40; i++) begin
            push_pixel(19'({$random(seed)} % NUM_PIX), color_t'($random(seed)), 1'b0, ok);
            if (!ok) begin
                dropped++;
            end
        end
        @(negedge clk);
        pix_push = 1'b0;
        assert (dropped > 0) else report_failure("burst never filled the pixel FIFO");
        read_reg(`FB_REG_STATUS, rd);
        assert (rd[0] == 1'b1) else report_mismatch("status_overflow", rd, 32'h1);
        write_reg(`FB_REG_STATUS, 32'h1);
        read_reg(`FB_REG_STATUS, rd);
        assert (rd[0] == 1'b0) else report_mismatch("status_overflow", rd, 32'h0);
        $display("burst dropped %0d pushes", dropped);
        finish_test("overflow_status", err0);

        err0 = errors;
        polls = 0;
        do begin
            read_reg(`FB_REG_COUNT, rd);
            polls++;
        end while (rd != 32'(accepted_count) && polls < 5000);
        assert (rd == 32'(accepted_count))
            else report_mismatch("pixel_count", rd, 32'(accepted_count));
        finish_test("pixel_count", err0);

        err0 = errors;
        wait_frame_start();
        run_frame(1);
        finish_test("frame_contents", err0);

        err0 = errors;
        write_reg(`FB_REG_CTRL, 32'h1);
        // more pixels land while the reader holds most bus slots
        fork
            run_frame(2);
            begin
                while (vga_blank) begin
                    @(negedge clk);
                end
                push_random_pairs(64);
                @(negedge clk);
                pix_push = 1'b0;
            end
        join
        write_reg(`FB_REG_CTRL, 32'h0);
        run_frame(1);
        finish_test("test_pattern", err0);

        // sync checks run for the whole simulation
        err0 = errors - sync_errors;
        assert (hs_periods > `FB_V_TOTAL) else report_failure("too few hsync pulses seen");
        finish_test("sync_timing", err0);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_frame_buffer

// ==== dv/sram_model.sv ====
`include "fb_defs.svh"

module sram_model (
    input  logic [`FB_ADDR_W-1:0] addr,
    inout  wire  [`FB_DATA_W-1:0] io,
    input  logic                  we_b,
    input  logic                  oe_b,
    input  logic                  ce_b,
    input  logic                  ub_b,
    input  logic                  lb_b
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`FB_DATA_W-1:0] mem [1 << `FB_ADDR_W];

    // power-up contents are all zero
    initial begin
        for (int i = 0; i < (1 << `FB_ADDR_W); i++) begin
            mem[i] = '0;
        end
    end

    // read drives only the enabled byte lanes
    assign io = (!ce_b && !oe_b && we_b) ?
                {(ub_b ? 8'hzz : mem[addr][15:8]), (lb_b ? 8'hzz : mem[addr][7:0])} : 'z;

    // write once the bus has settled
    always @(addr or io or we_b or ce_b or ub_b or lb_b) begin
        #1;
        if (!ce_b && !we_b) begin
            if (!ub_b) begin
                mem[addr][15:8] = io[15:8];
            end
            if (!lb_b) begin
                mem[addr][7:0] = io[7:0];
            end
        end
    end

endmodule : sram_model

// ==== hw/frame_buffer_top.sv ====
`include "fb_defs.svh"

module frame_buffer_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pix_push,
    input  fb_pkg::pixel_entry_t  pix_entry,
    output logic                  pix_full,
    input  logic                  cfg_we,
    input  logic [1:0]            cfg_addr,
    input  logic [31:0]           cfg_wdata,
    output logic [31:0]           cfg_rdata,
    output logic [`FB_ADDR_W-1:0] sram_addr,
    inout  wire  [`FB_DATA_W-1:0] sram_io,
    output logic                  sram_we_b,
    output logic                  sram_oe_b,
    output logic                  sram_ce_b,
    output logic                  sram_ub_b,
    output logic                  sram_lb_b,
    output logic                  hs,
    output logic                  vs,
    output logic                  vga_clk,
    output logic                  vga_blank,
    output fb_pkg::color_t        vga_rgb
);

    import fb_pkg::*;

    pixel_entry_t          fifo_data;
    logic                  fifo_empty;
    logic                  fifo_pop;
    logic                  overflow;
    logic                  pixel_done;
    logic                  pattern_en;
    logic                  sram_re_b;
    logic [`FB_ADDR_W-1:0] writer_addr;
    logic [`FB_ADDR_W-1:0] reader_addr;
    logic [`FB_DATA_W-1:0] writer_data;
    logic                  writer_ub;
    logic                  writer_lb;
    logic [9:0]            vga_row;
    logic [9:0]            vga_col;
    logic                  line_start;
    logic                  timing_blank;

    // reader owns the bus in its slots, reading both bytes
    assign sram_ce_b = 1'b0;
    assign sram_oe_b = sram_re_b;
    assign sram_addr = (!sram_re_b) ? reader_addr : writer_addr;
    assign sram_ub_b = (!sram_re_b) ? 1'b0 : ~writer_ub;
    assign sram_lb_b = (!sram_re_b) ? 1'b0 : ~writer_lb;
    assign sram_io   = (!sram_we_b) ? writer_data : 'z;

    pixel_fifo u_fifo (
        .clk(clk), .rst(rst), .push(pix_push), .din(pix_entry), .pop(fifo_pop),
        .dout(fifo_data), .empty(fifo_empty), .full(pix_full), .overflow(overflow)
    );

    vga_timing u_timing (
        .clk(clk), .rst(rst), .vga_row(vga_row), .vga_col(vga_col), .line_start(line_start),
        .hs(hs), .vs(vs), .vga_clk(vga_clk), .blank(timing_blank)
    );

    fb_writer u_writer (
        .clk(clk), .rst(rst), .fifo_empty(fifo_empty), .fifo_data(fifo_data),
        .fifo_pop(fifo_pop), .sram_re_b(sram_re_b), .sram_we_b(sram_we_b),
        .writer_addr(writer_addr), .writer_data(writer_data), .writer_ub(writer_ub),
        .writer_lb(writer_lb), .pixel_done(pixel_done)
    );

    fb_reader u_reader (
        .clk(clk), .rst(rst), .vga_row(vga_row), .vga_col(vga_col), .line_start(line_start),
        .blank_in(timing_blank), .pattern_en(pattern_en), .sram_re_b(sram_re_b),
        .reader_addr(reader_addr), .reader_data(sram_io), .blank(vga_blank), .rgb(vga_rgb)
    );

    fb_ctrl_regs u_regs (
        .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata), .overflow(overflow), .pixel_done(pixel_done),
        .pattern_en(pattern_en)
    );

endmodule : frame_buffer_top

// ==== hw/fb_ctrl_regs.sv ====
`include "fb_defs.svh"

module fb_ctrl_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        cfg_we,
    input  logic [1:0]  cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata,
    input  logic        overflow,
    input  logic        pixel_done,
    output logic        pattern_en
);

    import fb_pkg::*;

    ctrl_reg_t   ctrl;
    logic        ovf_flag;
    logic [31:0] pix_count;

    assign pattern_en = ctrl.pattern_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl      <= '0;
            ovf_flag  <= 1'b0;
            pix_count <= '0;
        end else begin
            if (cfg_we && (cfg_addr == `FB_REG_CTRL)) begin
                ctrl <= '{reserved: '0, pattern_en: cfg_wdata[0]};
            end
            // a new overflow wins over a clear
            if (overflow) begin
                ovf_flag <= 1'b1;
            end else if (cfg_we && (cfg_addr == `FB_REG_STATUS) && cfg_wdata[0]) begin
                ovf_flag <= 1'b0;
            end
            if (pixel_done) begin
                pix_count <= pix_count + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            `FB_REG_CTRL:   cfg_rdata = ctrl;
            `FB_REG_STATUS: cfg_rdata = {31'd0, ovf_flag};
            `FB_REG_COUNT:  cfg_rdata = pix_count;
            default:        cfg_rdata = '0;
        endcase
    end

endmodule : fb_ctrl_regs

// ==== hw/fb_reader.sv ====
`include "fb_defs.svh"

module fb_reader (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [9:0]            vga_row,
    input  logic [9:0]            vga_col,
    input  logic                  line_start,
    input  logic                  blank_in,
    input  logic                  pattern_en,
    output logic                  sram_re_b,
    output logic [`FB_ADDR_W-1:0] reader_addr,
    input  logic [`FB_DATA_W-1:0] reader_data,
    output logic                  blank,
    output fb_pkg::color_t        rgb
);

    import fb_pkg::*;

    localparam int ADDR_W      = `FB_ADDR_W;
    localparam int FRAME_WORDS = `FB_H_VISIBLE * `FB_V_VISIBLE * 3 / 2;

    logic                  active;
    logic                  frame_start;
    logic [3:0]            slot;
    logic                  read_slot;
    logic [`FB_DATA_W-1:0] a_q;
    logic [`FB_DATA_W-1:0] b_q;
    logic [`FB_DATA_W-1:0] c_q;
    color_t                pixel_q;
    color_t                stripe;
    color_t                stripe_d1;
    color_t                stripe_q;
    logic [1:0]            blank_pipe;

    // slot 0..2 read words a, b, c; slot 3 is left to the writer
    assign read_slot   = active && (slot[0] || slot[1] || slot[2]);
    assign sram_re_b   = ~read_slot;
    assign frame_start = line_start && (vga_row == 10'(`FB_V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            active      <= 1'b0;
            slot        <= 4'b1000;
            reader_addr <= '0;
        end else begin
            if (line_start) begin
                active <= 1'b1;
            end else if (slot[3] && (vga_col == 10'(`FB_H_VISIBLE - 1))) begin
                active <= 1'b0;
            end
            // phase is realigned at every line
            if (line_start) begin
                slot <= 4'b0001;
            end else begin
                slot <= {slot[2:0], slot[3]};
            end
            if (frame_start) begin
                reader_addr <= '0;
            end else if (read_slot) begin
                reader_addr <= reader_addr + 1'b1;
            end
        end
    end

    // word registers and pixel register carry no reset
    always_ff @(posedge clk) begin
        if (active && slot[0]) begin
            a_q <= reader_data;
        end
        if (active && slot[1]) begin
            b_q <= reader_data;
        end
        if (active && slot[2]) begin
            c_q <= reader_data;
        end
        // first pixel after b lands, second after c
        if (slot[2]) begin
            pixel_q <= {a_q, b_q[15:8]};
        end else if (slot[0]) begin
            pixel_q <= {b_q[7:0], c_q};
        end
    end

    // column bits 8..6 light the msb of r, g, b
    always_comb begin
        stripe           = '0;
        stripe.red[7]    = vga_col[8];
        stripe.green[7]  = vga_col[7];
        stripe.blue[7]   = vga_col[6];
    end

    // two clocks of delay match the pixel register
    always_ff @(posedge clk) begin
        stripe_d1 <= stripe;
        stripe_q  <= stripe_d1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            blank_pipe <= 2'b11;
        end else begin
            blank_pipe <= {blank_pipe[0], blank_in};
        end
    end

    assign blank = blank_pipe[1];
    assign rgb   = pattern_en ? stripe_q : pixel_q;

    a_addr_in_frame : assert property (@(posedge clk) disable iff (rst)
        !sram_re_b |-> (reader_addr < ADDR_W'(FRAME_WORDS)));

endmodule : fb_reader

// ==== hw/fb_writer.sv ====
`include "fb_defs.svh"

module fb_writer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fifo_empty,
    input  fb_pkg::pixel_entry_t  fifo_data,
    output logic                  fifo_pop,
    input  logic                  sram_re_b,
    output logic                  sram_we_b,
    output logic [`FB_ADDR_W-1:0] writer_addr,
    output logic [`FB_DATA_W-1:0] writer_data,
    output logic                  writer_ub,
    output logic                  writer_lb,
    output logic                  pixel_done
);

    import fb_pkg::*;

    localparam int ADDR_W = `FB_ADDR_W;

    logic              first_write;
    logic              odd_pixel;
    logic [18:0]       pid;
    color_t            pix_color;
    logic [ADDR_W-1:0] base_addr;

    assign pid       = fifo_data.pixel_id;
    assign pix_color = fifo_data.color;
    assign odd_pixel = pid[0];

    // pixel p starts at byte 3p
    assign base_addr   = ADDR_W'(pid) + ADDR_W'(pid >> 1);
    assign writer_addr = first_write ? base_addr : base_addr + 1'b1;

    // write in any slot the reader leaves free
    assign sram_we_b = ~(sram_re_b & ~fifo_empty);
    assign fifo_pop  = ~first_write & ~sram_we_b;

    // even pixels fill a whole word first, odd ones finish on a whole word
    assign writer_ub = ~odd_pixel | ~first_write;
    assign writer_lb = odd_pixel | first_write;

    always_comb begin
        case ({first_write, odd_pixel})
            2'b10:   writer_data = {pix_color.red, pix_color.green};
            2'b00:   writer_data = {pix_color.blue, 8'h00};
            2'b11:   writer_data = {8'h00, pix_color.red};
            default: writer_data = {pix_color.green, pix_color.blue};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            first_write <= 1'b1;
            pixel_done  <= 1'b0;
        end else begin
            if (!sram_we_b) begin
                first_write <= ~first_write;
            end
            pixel_done <= fifo_pop;
        end
    end

    // head entry must not move between the two halves of a pixel
    a_head_held : assert property (@(posedge clk) disable iff (rst)
        (!sram_we_b && first_write) |=> $stable(fifo_data));

endmodule : fb_writer

// ==== hw/vga_timing.sv ====
`include "fb_defs.svh"

module vga_timing (
    input  logic       clk,
    input  logic       rst,
    output logic [9:0] vga_row,
    output logic [9:0] vga_col,
    output logic       line_start,
    output logic       hs,
    output logic       vs,
    output logic       vga_clk,
    output logic       blank
);

    logic       pix_en;
    logic       col_wrap;
    logic [9:0] col_next;
    logic [9:0] row_next;
    logic       next_line_visible;

    // one column per two clocks
    assign vga_clk = pix_en;

    always_comb begin
        col_wrap = pix_en && (vga_col == 10'(`FB_H_TOTAL - 1));
        if (col_wrap) begin
            col_next = '0;
        end else if (pix_en) begin
            col_next = vga_col + 10'd1;
        end else begin
            col_next = vga_col;
        end
        if (col_wrap) begin
            row_next = (vga_row == 10'(`FB_V_TOTAL - 1)) ? '0 : vga_row + 10'd1;
        end else begin
            row_next = vga_row;
        end
        // the line after row_next is on screen
        next_line_visible = (row_next == 10'(`FB_V_TOTAL - 1)) ||
                            (row_next < 10'(`FB_V_VISIBLE - 1));
    end

    // outputs decoded from next counts so they line up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_en     <= 1'b0;
            vga_col    <= '0;
            vga_row    <= 10'(`FB_V_VISIBLE);
            hs         <= 1'b1;
            vs         <= 1'b1;
            blank      <= 1'b1;
            line_start <= 1'b0;
        end else begin
            pix_en     <= ~pix_en;
            vga_col    <= col_next;
            vga_row    <= row_next;
            hs         <= !((col_next >= 10'(`FB_H_FRONT)) && (col_next < 10'(`FB_H_SYNC)));
            vs         <= !((row_next >= 10'(`FB_V_FRONT)) && (row_next < 10'(`FB_V_SYNC)));
            blank      <= !((col_next < 10'(`FB_H_VISIBLE)) && (row_next < 10'(`FB_V_VISIBLE)));
            // first clock of the last column before a visible line
            line_start <= pix_en && (col_next == 10'(`FB_H_TOTAL - 1)) && next_line_visible;
        end
    end

endmodule : vga_timing

// ==== hw/pixel_fifo.sv ====
`include "fb_defs.svh"

module pixel_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  fb_pkg::pixel_entry_t din,
    input  logic                 pop,
    output fb_pkg::pixel_entry_t dout,
    output logic                 empty,
    output logic                 full,
    output logic                 overflow
);

    import fb_pkg::*;

    localparam int DEPTH = `FB_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    pixel_entry_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (PTR_W + 1)'(DEPTH));
    assign dout  = mem[rd_ptr];

    // storage has no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
            // push while full is lost
            overflow <= push && full;
        end
    end

    // the writer only pops a head it has seen
    a_no_pop_empty : assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule : pixel_fifo

// ==== hw/fb_pkg.sv ====
package fb_pkg;

    // one pixel, 24 bits
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } color_t;

    // pixel_id is row * 640 + col
    typedef struct packed {
        logic [18:0] pixel_id;
        color_t      color;
    } pixel_entry_t;

    // control register layout
    typedef struct packed {
        logic [30:0] reserved;
        logic        pattern_en;
    } ctrl_reg_t;

endpackage : fb_pkg

// ==== hw/fb_defs.svh ====
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// horizontal timing, in pixel columns
`define FB_H_VISIBLE 640
`define FB_H_FRONT   656
`define FB_H_SYNC    752
`define FB_H_TOTAL   800

// vertical timing, in lines
`define FB_V_VISIBLE 480
`define FB_V_FRONT   490
`define FB_V_SYNC    492
`define FB_V_TOTAL   525

// external sram
`define FB_ADDR_W 20
`define FB_DATA_W 16

// pixel fifo, power of two
`define FB_FIFO_DEPTH 16

// register map
`define FB_REG_CTRL   2'd0
`define FB_REG_STATUS 2'd1
`define FB_REG_COUNT  2'd2

`endif
